/* logic/aluPkg.sv */
package aluPkg;

  // Data-processing opcode, instruction bits 24 down to 21
  typedef logic [24:21] opcode_t;

  localparam opcode_t opAnd = 4'b0000;
  localparam opcode_t opEor = 4'b0001;
  localparam opcode_t opSub = 4'b0010;
  localparam opcode_t opRsb = 4'b0011;
  localparam opcode_t opAdd = 4'b0100;
  localparam opcode_t opAdc = 4'b0101;
  localparam opcode_t opSbc = 4'b0110;
  localparam opcode_t opRsc = 4'b0111;
  localparam opcode_t opTst = 4'b1000;
  localparam opcode_t opTeq = 4'b1001;
  localparam opcode_t opCmp = 4'b1010;
  localparam opcode_t opCmn = 4'b1011;
  localparam opcode_t opOrr = 4'b1100;
  localparam opcode_t opMov = 4'b1101;
  localparam opcode_t opBic = 4'b1110;
  localparam opcode_t opMvn = 4'b1111;

  typedef enum logic [2:0] {
    funcAnd   = 3'b000,
    funcXor   = 3'b001,
    funcSum   = 3'b010,
    funcOr    = 3'b011,
    funcPassB = 3'b100   // Second operand only
  } aluFunc_t;

  typedef enum logic [1:0] {
    carryZero,
    carryOne,
    carryFlag            // Carry-in from the C flag
  } carrySel_t;

  // Bit 1 takes C and V from the adder, bit 0 keeps V anyway
  typedef logic [1:0] flagCode_t;

  typedef logic [3:0] flags_t;  // N Z C V

  localparam int flagN = 3;
  localparam int flagZ = 2;
  localparam int flagC = 1;
  localparam int flagV = 0;

endpackage

/* logic/aluDecoder.sv */
module aluDecoder import aluPkg::*; (
  input  logic      aluEnable,
  input  opcode_t   opcode,
  input  logic      carryFlag,      // Current C flag
  output aluFunc_t  func,
  output logic      invertB,
  output logic      swapInputs,
  output logic      carryIn,
  output flagCode_t flagCode,
  output logic      suppressWrite
);

  carrySel_t carrySel;

  always_comb begin
    func          = funcSum;        // Plain add when the ALU is off
    invertB       = 1'b0;
    swapInputs    = 1'b0;
    carrySel      = carryZero;
    flagCode      = 2'b00;
    suppressWrite = 1'b0;
    if (aluEnable) begin
      unique case (opcode)
        opAnd: func = funcAnd;
        opEor: func = funcXor;
        opSub: begin
          invertB  = 1'b1;
          carrySel = carryOne;
          flagCode = 2'b10;
        end
        opRsb: begin
          invertB    = 1'b1;
          swapInputs = 1'b1;
          carrySel   = carryOne;
          flagCode   = 2'b10;
        end
        opAdd: flagCode = 2'b11;     // KeepV
        opAdc: begin
          carrySel = aluPkg::carryFlag;
          flagCode = 2'b10;
        end
        opSbc: begin
          invertB  = 1'b1;
          carrySel = aluPkg::carryFlag;
          flagCode = 2'b10;
        end
        opRsc: begin
          invertB    = 1'b1;
          swapInputs = 1'b1;
          carrySel   = aluPkg::carryFlag;
          flagCode   = 2'b10;
        end
        opTst: begin
          func          = funcAnd;
          suppressWrite = 1'b1;
        end
        opTeq: begin
          func          = funcXor;
          suppressWrite = 1'b1;
        end
        opCmp: begin
          invertB       = 1'b1;
          carrySel      = carryOne;
          flagCode      = 2'b10;
          suppressWrite = 1'b1;
        end
        opCmn: begin
          flagCode      = 2'b10;
          suppressWrite = 1'b1;
        end
        opOrr: func = funcOr;
        opMov: func = funcPassB;
        opBic: begin
          func    = funcAnd;        // A and not B
          invertB = 1'b1;
        end
        opMvn: begin
          func    = funcPassB;
          invertB = 1'b1;
        end
      endcase
    end
  end

  // The port name hides the enum value, hence the package scope
  always_comb begin
    case (carrySel)
      carryOne:          carryIn = 1'b1;
      aluPkg::carryFlag: carryIn = carryFlag;
      default:           carryIn = 1'b0;
    endcase
  end

endmodule

/* logic/aluCore.sv */
module aluCore import aluPkg::*; #(
  parameter int DataWidth = 32
) (
  input  logic [DataWidth-1:0] a,
  input  logic [DataWidth-1:0] b,
  input  aluFunc_t             func,
  input  logic                 invertB,
  input  logic                 swapInputs,
  input  logic                 carryIn,
  output logic [DataWidth-1:0] result,
  output logic                 carryOut,
  output logic                 overflow
);

  localparam int Msb = DataWidth - 1;

  logic [DataWidth-1:0] opA;
  logic [DataWidth-1:0] opB;
  logic [DataWidth-1:0] opBFinal;   // After optional invert
  logic [DataWidth:0]   sum;        // One extra bit for carry
  logic                 signA;
  logic                 signB;
  logic                 signSum;

  // Swap first so RSB and RSC invert the original A
  assign opA = swapInputs ? b : a;
  assign opB = swapInputs ? a : b;

  assign opBFinal = invertB ? ~opB : opB;

  assign sum = {1'b0, opA} + {1'b0, opBFinal} + {{DataWidth{1'b0}}, carryIn};

  assign signA   = opA[Msb];
  assign signB   = opBFinal[Msb];
  assign signSum = sum[Msb];

  assign carryOut = sum[DataWidth];                         // Not-borrow on subtract
  assign overflow = (signA == signB) && (signSum != signA); // Same-sign inputs, sign flipped

  always_comb begin
    case (func)
      funcAnd:   result = opA & opBFinal;
      funcXor:   result = opA ^ opBFinal;
      funcOr:    result = opA | opBFinal;
      funcPassB: result = opBFinal;
      default:   result = sum[DataWidth-1:0];   // funcSum
    endcase
  end

endmodule

/* logic/flagRegister.sv */
module flagRegister import aluPkg::*; #(
  parameter int DataWidth = 32
) (
  input  logic                 clk,
  input  logic                 arstN,
  input  logic                 update,      // Accept strobe
  input  logic                 setFlags,
  input  flagCode_t            flagCode,
  input  logic [DataWidth-1:0] result,
  input  logic                 carryOut,
  input  logic                 overflow,
  output flags_t               flags
);

  logic writeFlags;
  logic takeCv;
  logic keepV;

  assign writeFlags = update && setFlags;
  assign takeCv     = flagCode[1];
  assign keepV      = flagCode[0];

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      flags <= '0;
    end else if (writeFlags) begin
      flags[flagN] <= result[DataWidth-1];
      flags[flagZ] <= (result == '0);
      // Logical ops keep C and V, no shifter carry here
      if (takeCv) begin
        flags[flagC] <= carryOut;
        if (!keepV) begin
          flags[flagV] <= overflow;
        end
      end
    end
  end

endmodule

/* logic/executeStage.sv */
module executeStage import aluPkg::*; #(
  parameter int DataWidth = 32
) (
  input  logic                 clk,
  input  logic                 arstN,
  input  logic                 inValid,
  output logic                 inReady,
  input  logic                 aluEnable,
  input  opcode_t              opcode,
  input  logic                 setFlags,
  input  logic [DataWidth-1:0] operandA,
  input  logic [DataWidth-1:0] operandB,
  output logic                 outValid,
  input  logic                 outReady,
  output logic [DataWidth-1:0] result,
  output logic                 writeReg,
  output flags_t               flags
);

  aluFunc_t             func;
  logic                 invertB;
  logic                 swapInputs;
  logic                 carryIn;
  flagCode_t            flagCode;
  logic                 suppressWrite;
  logic [DataWidth-1:0] aluResult;
  logic                 carryOut;
  logic                 overflow;
  logic                 accept;

  // Output slot is empty or drains this cycle
  assign inReady = !outValid || outReady;
  assign accept  = inValid && inReady;

  aluDecoder aluDecoder_inst (
    .aluEnable     (aluEnable),
    .opcode        (opcode),
    .carryFlag     (flags[flagC]),
    .func          (func),
    .invertB       (invertB),
    .swapInputs    (swapInputs),
    .carryIn       (carryIn),
    .flagCode      (flagCode),
    .suppressWrite (suppressWrite)
  );

  aluCore #(
    .DataWidth (DataWidth)
  ) aluCore_inst (
    .a          (operandA),
    .b          (operandB),
    .func       (func),
    .invertB    (invertB),
    .swapInputs (swapInputs),
    .carryIn    (carryIn),
    .result     (aluResult),
    .carryOut   (carryOut),
    .overflow   (overflow)
  );

  flagRegister #(
    .DataWidth (DataWidth)
  ) flagRegister_inst (
    .clk      (clk),
    .arstN    (arstN),
    .update   (accept),
    .setFlags (setFlags),
    .flagCode (flagCode),
    .result   (aluResult),
    .carryOut (carryOut),
    .overflow (overflow),
    .flags    (flags)
  );

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      outValid <= 1'b0;
    end else if (inReady) begin
      outValid <= inValid;    // Refill or drain
    end
  end

  // Payload holds under back-pressure
  always_ff @(posedge clk) begin
    if (accept) begin
      result   <= aluResult;
      writeReg <= !suppressWrite;
    end
  end

endmodule

/* tests/executeStage_checker.sv */
module executeStage_checker #(
  parameter int DataWidth = 32
) (
  input logic                 clk,
  input logic                 arstN,
  input logic                 inReady,
  input logic                 outValid,
  input logic                 outReady,
  input logic [DataWidth-1:0] result,
  input logic                 writeReg
);
  timeunit 1ns;
  timeprecision 1ps;

  // Output register starts empty
  resetEmpty: assert property (@(posedge clk) $rose(arstN) |-> !outValid)
    else $error("outValid high in the cycle after reset release");

  stallHold: assert property (@(posedge clk) disable iff (!arstN)
    (outValid && !outReady) |=> (outValid && $stable(result) && $stable(writeReg)))
    else $error("Output payload changed while stalled");

  stallBlocks: assert property (@(posedge clk) disable iff (!arstN)
    (outValid && !outReady) |-> !inReady)
    else $error("inReady high while the output is stalled");

endmodule

bind executeStage executeStage_checker #(
  .DataWidth (DataWidth)
) executeStage_checker_inst (
  .clk      (clk),
  .arstN    (arstN),
  .inReady  (inReady),
  .outValid (outValid),
  .outReady (outReady),
  .result   (result),
  .writeReg (writeReg)
);

/* tests/executeStageTb.sv */
module executeStageTb import aluPkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int DataWidth = 32;
  localparam int NumOps    = 400;
  localparam int Timeout   = 50;   // Cycles per wait loop
  localparam longint MaxSigned = (64'sd1 << (DataWidth - 1)) - 64'sd1;
  localparam longint MinSigned = -(64'sd1 << (DataWidth - 1));

  logic                 clk;
  logic                 arstN;
  logic                 inValid;
  logic                 inReady;
  logic                 aluEnable;
  opcode_t              opcode;
  logic                 setFlags;
  logic [DataWidth-1:0] operandA;
  logic [DataWidth-1:0] operandB;
  logic                 outValid;
  logic                 outReady;
  logic [DataWidth-1:0] result;
  logic                 writeReg;
  flags_t               flags;

  int     seed;
  int     resultErrors;
  int     writeErrors;
  int     flagErrors;
  int     protocolErrors;
  logic   timedOut;
  flags_t modelFlags;      // Reference NZCV
  string  lastName;

  logic [DataWidth-1:0] expResultQ[$];
  logic                 expWriteQ[$];
  string                expNameQ[$];

  executeStage #(
    .DataWidth (DataWidth)
  ) executeStage_inst (
    .clk       (clk),
    .arstN     (arstN),
    .inValid   (inValid),
    .inReady   (inReady),
    .aluEnable (aluEnable),
    .opcode    (opcode),
    .setFlags  (setFlags),
    .operandA  (operandA),
    .operandB  (operandB),
    .outValid  (outValid),
    .outReady  (outReady),
    .result    (result),
    .writeReg  (writeReg),
    .flags     (flags)
  );

  always #10 clk = ~clk;

  // x + y + cin with unsigned carry and signed overflow
  task automatic addWide(input logic [DataWidth-1:0] x, input logic [DataWidth-1:0] y,
                         input logic cin, output logic [DataWidth-1:0] res,
                         output logic c, output logic v);
    longint total;
    longint signedTotal;
    total       = longint'(x) + longint'(y) + longint'(cin);
    signedTotal = longint'($signed(x)) + longint'($signed(y)) + longint'(cin);
    res = total[DataWidth-1:0];
    c   = total[DataWidth];
    v   = (signedTotal > MaxSigned) || (signedTotal < MinSigned);
  endtask

  // x - y - borrow with C as the not-borrow
  task automatic subWide(input logic [DataWidth-1:0] x, input logic [DataWidth-1:0] y,
                         input logic borrow, output logic [DataWidth-1:0] res,
                         output logic c, output logic v);
    longint diff;
    longint signedDiff;
    diff       = longint'(x) - longint'(y) - longint'(borrow);
    signedDiff = longint'($signed(x)) - longint'($signed(y)) - longint'(borrow);
    res = diff[DataWidth-1:0];
    c   = longint'(x) >= (longint'(y) + longint'(borrow));
    v   = (signedDiff > MaxSigned) || (signedDiff < MinSigned);
  endtask

  task automatic modelOp(input logic enable, input opcode_t op, input logic sFlag,
                         input logic [DataWidth-1:0] a, input logic [DataWidth-1:0] b,
                         input flags_t prev, output logic [DataWidth-1:0] res,
                         output logic wr, output flags_t next, output string name);
    logic c;
    logic v;
    logic unusedC;
    logic unusedV;
    c    = prev[flagC];
    v    = prev[flagV];
    wr   = 1'b1;
    name = "logical";
    if (!enable) begin
      addWide(a, b, 1'b0, res, unusedC, unusedV);   // ALU off so only N and Z update
      name = "aluOff";
    end else begin
      case (op)
        opAnd: res = a & b;
        opEor: res = a ^ b;
        opOrr: res = a | b;
        opMov: res = b;
        opBic: res = a & ~b;
        opMvn: res = ~b;
        opAdd: begin
          addWide(a, b, 1'b0, res, c, unusedV);     // V kept on ADD
          name = "arith";
        end
        opAdc: begin
          addWide(a, b, prev[flagC], res, c, v);
          name = "arith";
        end
        opSub: begin
          subWide(a, b, 1'b0, res, c, v);
          name = "arith";
        end
        opRsb: begin
          subWide(b, a, 1'b0, res, c, v);
          name = "arith";
        end
        opSbc: begin
          subWide(a, b, !prev[flagC], res, c, v);
          name = "arith";
        end
        opRsc: begin
          subWide(b, a, !prev[flagC], res, c, v);
          name = "arith";
        end
        opTst: res = a & b;
        opTeq: res = a ^ b;
        opCmp: subWide(a, b, 1'b0, res, c, v);
        opCmn: addWide(a, b, 1'b0, res, c, v);
        default: res = '0;
      endcase
      if (op == opTst || op == opTeq || op == opCmp || op == opCmn) begin
        wr   = 1'b0;
        name = "compare";
      end
    end
    next = prev;
    if (sFlag) begin
      next[flagN] = res[DataWidth-1];
      next[flagZ] = (res == '0);
      next[flagC] = c;
      next[flagV] = v;
    end
  endtask

  task automatic pickOperand(output logic [DataWidth-1:0] value);
    logic [31:0] r;
    r = $random(seed);
    case (r[2:0])
      3'd0:    value = '0;
      3'd1:    value = 32'h7fff_ffff;
      3'd2:    value = 32'h8000_0000;
      3'd3:    value = 32'hffff_ffff;
      default: value = $random(seed);
    endcase
  endtask

  // One clock edge with fresh back-pressure
  task automatic tickCycle();
    logic [31:0] r;
    @(posedge clk);
    r = $random(seed);
    outReady <= (r[1:0] != 2'b00);
  endtask

  task automatic sendOp();
    logic [31:0]          r;
    logic [DataWidth-1:0] a;
    logic [DataWidth-1:0] b;
    int                   waitCycles;
    logic                 accepted;
    r = $random(seed);
    pickOperand(a);
    pickOperand(b);
    inValid   <= 1'b1;
    aluEnable <= (r[2:0] != 3'b000);
    opcode    <= r[7:4];
    setFlags  <= (r[9:8] != 2'b00);
    operandA  <= a;
    operandB  <= b;
    waitCycles = 0;
    accepted   = 1'b0;
    while (!accepted && waitCycles < Timeout) begin
      tickCycle();
      accepted = inValid && inReady;   // Pre-edge values
      waitCycles++;
    end
    if (!accepted) begin
      $display("Timeout: operation not accepted within %0d cycles", Timeout);
      protocolErrors++;
      timedOut = 1'b1;
    end
  endtask

  // Reference model and result checks
  always @(posedge clk) begin
    logic [DataWidth-1:0] gotExp;
    logic                 gotWr;
    string                gotName;
    logic [DataWidth-1:0] newRes;
    logic                 newWr;
    flags_t               newFlags;
    string                newName;
    if (arstN) begin
      if (outValid && outReady) begin
        if (expResultQ.size() == 0) begin
          $display("Output handshake seen with no result outstanding");
          protocolErrors++;
        end else begin
          gotExp  = expResultQ.pop_front();
          gotWr   = expWriteQ.pop_front();
          gotName = expNameQ.pop_front();
          assert (result == gotExp) else begin
            $display("CHECK FAILED %s result: expected %h, actual %h", gotName, gotExp, result);
            resultErrors++;
          end
          assert (writeReg == gotWr) else begin
            $display("CHECK FAILED %s writeReg: expected %b, actual %b", gotName, gotWr,
                     writeReg);
            writeErrors++;
          end
        end
      end
      if (inValid && inReady) begin
        modelOp(aluEnable, opcode, setFlags, operandA, operandB, modelFlags,
                newRes, newWr, newFlags, newName);
        modelFlags = newFlags;
        lastName   = newName;
        expResultQ.push_back(newRes);
        expWriteQ.push_back(newWr);
        expNameQ.push_back(newName);
      end
    end
  end

  // Flags settle one cycle after the accept
  always @(negedge clk) begin
    if (arstN && !timedOut) begin
      assert (flags == modelFlags) else begin
        $display("CHECK FAILED %s flags: expected %b, actual %b", lastName, modelFlags, flags);
        flagErrors++;
      end
    end
  end

  initial begin
    logic [31:0] r;
    int          waitCycles;
    clk            = 1'b0;
    seed           = 48247;
    resultErrors   = 0;
    writeErrors    = 0;
    flagErrors     = 0;
    protocolErrors = 0;
    timedOut       = 1'b0;
    modelFlags     = '0;
    lastName       = "reset";
    arstN     <= 1'b0;
    inValid   <= 1'b0;
    aluEnable <= 1'b0;
    opcode    <= opAnd;
    setFlags  <= 1'b0;
    operandA  <= '0;
    operandB  <= '0;
    outReady  <= 1'b0;
    repeat (4) @(posedge clk);
    arstN <= 1'b1;
    @(negedge clk);
    assert (!outValid && inReady && flags == '0) else begin
      $display("CHECK FAILED reset: expected outValid 0 inReady 1 flags 0000, actual %b %b %b",
               outValid, inReady, flags);
      protocolErrors++;
    end
    @(posedge clk);
    for (int i = 0; i < NumOps && !timedOut; i++) begin
      sendOp();
      r = $random(seed);
      if (r[1:0] == 2'b00) begin
        inValid <= 1'b0;                  // Idle gap
        repeat (r[3:2] + 1) tickCycle();
      end
    end
    inValid <= 1'b0;
    waitCycles = 0;
    while (expResultQ.size() != 0 && waitCycles < Timeout && !timedOut) begin
      tickCycle();
      waitCycles++;
    end
    if (expResultQ.size() != 0) begin
      $display("Timeout: %0d results never left the stage", expResultQ.size());
      protocolErrors++;
      timedOut = 1'b1;
    end
    repeat (2) tickCycle();
    $display("Errors: result %0d, writeReg %0d, flags %0d, protocol %0d",
             resultErrors, writeErrors, flagErrors, protocolErrors);
    if (resultErrors + writeErrors + flagErrors + protocolErrors == 0 && !timedOut) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

/* vlog.f */
logic/aluPkg.sv
logic/aluDecoder.sv
logic/aluCore.sv
logic/flagRegister.sv
logic/executeStage.sv
tests/executeStage_checker.sv
tests/executeStageTb.sv

/* run.sh */
#!/bin/sh
# Build and run the execute stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module executeStageTb \
  -Mdir obj_dir \
  -f vlog.f

# A failing assertion may end the run early, the log decides
./obj_dir/VexecuteStageTb > sim.log 2>&1 || true
cat sim.log

if grep -qF '** FAIL **' sim.log || ! grep -qF '** PASS **' sim.log; then
  echo "Simulation failed, see sim.log"
  exit 1
fi
echo "Simulation passed"
